//--- gbc_io_checker.sv
`default_nettype none

module gbc_io_checker (
   input wire                        clock_main,
   input wire                        synch_reset,
   input wire gbc_io_pkg::io_req_t   cpu_req,
   input wire gbc_io_pkg::irq_vec_t  irq_pending
);

   logic [4:0] ie_shadow;   // IE as last written on the bus
   int         assert_fail_count = 0;

   always_ff @(posedge clock_main) begin
      if (synch_reset)
         ie_shadow <= '0;
      else if (cpu_req.we && cpu_req.addr == 16'hFFFF)
         ie_shadow <= cpu_req.wdata[4:0];
   end

   // ====================================================================
   // Port rules
   // ====================================================================

   pending_needs_ie: assert property (@(posedge clock_main) disable iff (synch_reset)
      (irq_pending & ~ie_shadow) == 5'b00000)
   else begin
      assert_fail_count = assert_fail_count + 1;
      $error("irq_pending bit set while its IE bit is clear");
   end

   pending_clear_after_reset: assert property (@(posedge clock_main)
      synch_reset |=> irq_pending == 5'b00000)
   else begin
      assert_fail_count = assert_fail_count + 1;
      $error("irq_pending not zero after reset");
   end

   strobes_exclusive: assert property (@(posedge clock_main)
      !(cpu_req.we && cpu_req.re))
   else begin
      assert_fail_count = assert_fail_count + 1;
      $error("write and read strobes high together");
   end

endmodule

bind gbc_io_top gbc_io_checker gbc_io_checker_i (
   .clock_main  (clock_main),
   .synch_reset (synch_reset),
   .cpu_req     (cpu_req),
   .irq_pending (irq_pending)
);

`default_nettype wire

//--- gbc_io_pkg.sv
`default_nettype none

package gbc_io_pkg;

   // ====================================================================
   // Bus types
   // ====================================================================

   // Request as issued by the CPU, one strobe at a time
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we;
      logic        re;
   } io_req_t;

   // Access routed to a single block
   typedef struct packed {
      logic [7:0] offset;   // Low address byte
      logic [7:0] wdata;
      logic       we;
      logic       re;
   } io_access_t;

   typedef enum logic [1:0] {
      BLK_NONE,
      BLK_TIMER,
      BLK_IRQ,
      BLK_BANK
   } io_block_e;

   // Declared MSB first, so vblank lands on bit 0 as in IF
   typedef struct packed {
      logic joypad;
      logic serial;
      logic timer;
      logic lcdstat;
      logic vblank;
   } irq_vec_t;

   // ====================================================================
   // Register map
   // ====================================================================

   localparam logic [7:0] IO_PAGE = 8'hFF;   // High address byte

   localparam logic [7:0] DIV_OFS  = 8'h04;
   localparam logic [7:0] TIMA_OFS = 8'h05;
   localparam logic [7:0] TMA_OFS  = 8'h06;
   localparam logic [7:0] TAC_OFS  = 8'h07;

   localparam logic [7:0] IF_OFS = 8'h0F;
   localparam logic [7:0] IE_OFS = 8'hFF;

   // Generic register bank
   // SB (01) is left out of the bank; the nine entries are SC, KEY1,
   // 6C and 72-77
   localparam int BANK_COUNT = 9;

   localparam logic [0:BANK_COUNT-1][7:0] BANK_OFS = '{
      8'h02, 8'h4D, 8'h6C, 8'h72, 8'h73, 8'h74, 8'h75, 8'h76, 8'h77
   };

   localparam logic [0:BANK_COUNT-1][7:0] BANK_RESET = '{
      8'h7C, 8'hFD, 8'hFE, 8'h00, 8'h00, 8'h00, 8'h8F, 8'h00, 8'h00
   };

   // Bits 7 and 8 are FF76 and FF77
   localparam logic [BANK_COUNT-1:0] BANK_READ_ONLY = 9'b1_1000_0000;

   // Read fill values
   localparam logic [7:0] UNMAPPED_DATA  = 8'hFF;
   localparam logic [7:0] IF_UNUSED_BITS = 8'hE0;   // IF bits 7:5 read high

endpackage

`default_nettype wire

//--- gbc_io_top.sv
`default_nettype none

module gbc_io_top (
   input  wire                        clock_main,
   input  wire                        synch_reset,
   input  wire gbc_io_pkg::io_req_t   cpu_req,
   input  wire gbc_io_pkg::irq_vec_t  irq_sources,   // timer field unused
   output logic [7:0]                 cpu_rdata,
   output gbc_io_pkg::irq_vec_t       irq_pending
);

   gbc_io_pkg::io_access_t timer_acc;
   gbc_io_pkg::io_access_t irq_acc;
   gbc_io_pkg::io_access_t bank_acc;
   logic [7:0]             timer_rdata;
   logic [7:0]             irq_rdata;
   logic [7:0]             bank_rdata;
   logic                   timer_irq;

   io_bus_decoder io_bus_decoder_i (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .cpu_req     (cpu_req),
      .timer_acc   (timer_acc),
      .irq_acc     (irq_acc),
      .bank_acc    (bank_acc),
      .timer_rdata (timer_rdata),
      .irq_rdata   (irq_rdata),
      .bank_rdata  (bank_rdata),
      .cpu_rdata   (cpu_rdata)
   );

   io_register_bank io_register_bank_i (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .bank_acc    (bank_acc),
      .bank_rdata  (bank_rdata)
   );

   timer_unit timer_unit_i (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .timer_acc   (timer_acc),
      .timer_rdata (timer_rdata),
      .timer_irq   (timer_irq)
   );

   interrupt_unit interrupt_unit_i (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .irq_acc     (irq_acc),
      .irq_sources (irq_sources),
      .timer_irq   (timer_irq),
      .irq_rdata   (irq_rdata),
      .irq_pending (irq_pending)
   );

endmodule

`default_nettype wire

//--- interrupt_unit.sv
`default_nettype none

module interrupt_unit (
   input  wire                          clock_main,
   input  wire                          synch_reset,
   input  wire gbc_io_pkg::io_access_t  irq_acc,
   input  wire gbc_io_pkg::irq_vec_t    irq_sources,
   input  wire                          timer_irq,
   output logic [7:0]                   irq_rdata,
   output gbc_io_pkg::irq_vec_t         irq_pending
);

   gbc_io_pkg::irq_vec_t req_vec;
   logic [4:0]           if_q;
   logic [7:0]           ie_q;
   logic                 if_wr;
   logic                 ie_wr;

   assign if_wr = irq_acc.we && (irq_acc.offset == gbc_io_pkg::IF_OFS);
   assign ie_wr = irq_acc.we && (irq_acc.offset == gbc_io_pkg::IE_OFS);

   // Internal timer request replaces the external timer line
   always_comb begin
      req_vec       = irq_sources;
      req_vec.timer = timer_irq;
   end

   // ====================================================================
   // IF / IE state
   // ====================================================================

   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         if_q <= '0;
         ie_q <= '0;
      end else begin
         if (if_wr)
            if_q <= irq_acc.wdata[4:0];   // Write wins over new requests
         else
            if_q <= if_q | req_vec;

         if (ie_wr)
            ie_q <= irq_acc.wdata;
      end
   end

   assign irq_pending = gbc_io_pkg::irq_vec_t'(if_q & ie_q[4:0]);

   always_comb begin
      irq_rdata = gbc_io_pkg::UNMAPPED_DATA;
      if (irq_acc.re) begin
         if (irq_acc.offset == gbc_io_pkg::IF_OFS)
            irq_rdata = gbc_io_pkg::IF_UNUSED_BITS | {3'b000, if_q};
         else if (irq_acc.offset == gbc_io_pkg::IE_OFS)
            irq_rdata = ie_q;   // Full byte
      end
   end

endmodule

`default_nettype wire

//--- io_bus_decoder.sv
`default_nettype none

module io_bus_decoder (
   input  wire                       clock_main,
   input  wire                       synch_reset,
   input  wire gbc_io_pkg::io_req_t  cpu_req,
   output gbc_io_pkg::io_access_t    timer_acc,
   output gbc_io_pkg::io_access_t    irq_acc,
   output gbc_io_pkg::io_access_t    bank_acc,
   input  wire [7:0]                 timer_rdata,
   input  wire [7:0]                 irq_rdata,
   input  wire [7:0]                 bank_rdata,
   output logic [7:0]                cpu_rdata
);

   gbc_io_pkg::io_block_e blk_sel;
   logic                  bank_hit;
   logic [7:0]            rdata_mux;

   // Access for one block, strobes dropped unless selected
   function automatic gbc_io_pkg::io_access_t gate_access(
      input gbc_io_pkg::io_req_t req,
      input logic                selected
   );
      gbc_io_pkg::io_access_t acc;
      acc.offset = req.addr[7:0];
      acc.wdata  = req.wdata;
      acc.we     = req.we & selected;
      acc.re     = req.re & selected;
      return acc;
   endfunction

   // ====================================================================
   // Block select
   // ====================================================================

   always_comb begin
      bank_hit = 1'b0;
      for (int i = 0; i < gbc_io_pkg::BANK_COUNT; i++) begin
         if (cpu_req.addr[7:0] == gbc_io_pkg::BANK_OFS[i])
            bank_hit = 1'b1;
      end
   end

   always_comb begin
      blk_sel = gbc_io_pkg::BLK_NONE;   // Also for anything off page FF
      if (cpu_req.addr[15:8] == gbc_io_pkg::IO_PAGE) begin
         case (cpu_req.addr[7:0])
            gbc_io_pkg::DIV_OFS, gbc_io_pkg::TIMA_OFS,
            gbc_io_pkg::TMA_OFS, gbc_io_pkg::TAC_OFS:
               blk_sel = gbc_io_pkg::BLK_TIMER;
            gbc_io_pkg::IF_OFS, gbc_io_pkg::IE_OFS:
               blk_sel = gbc_io_pkg::BLK_IRQ;
            default:
               if (bank_hit)
                  blk_sel = gbc_io_pkg::BLK_BANK;
         endcase
      end
   end

   assign timer_acc = gate_access(cpu_req, blk_sel == gbc_io_pkg::BLK_TIMER);
   assign irq_acc   = gate_access(cpu_req, blk_sel == gbc_io_pkg::BLK_IRQ);
   assign bank_acc  = gate_access(cpu_req, blk_sel == gbc_io_pkg::BLK_BANK);

   // ====================================================================
   // Read return
   // ====================================================================

   always_comb begin
      case (blk_sel)
         gbc_io_pkg::BLK_TIMER: rdata_mux = timer_rdata;
         gbc_io_pkg::BLK_IRQ:   rdata_mux = irq_rdata;
         gbc_io_pkg::BLK_BANK:  rdata_mux = bank_rdata;
         default:               rdata_mux = gbc_io_pkg::UNMAPPED_DATA;
      endcase
   end

   // Held until the next read
   always_ff @(posedge clock_main) begin
      if (synch_reset)
         cpu_rdata <= gbc_io_pkg::UNMAPPED_DATA;
      else if (cpu_req.re)
         cpu_rdata <= rdata_mux;
   end

endmodule

`default_nettype wire

//--- io_register_bank.sv
`default_nettype none

module io_register_bank (
   input  wire                          clock_main,
   input  wire                          synch_reset,
   input  wire gbc_io_pkg::io_access_t  bank_acc,
   output logic [7:0]                   bank_rdata
);

   logic [7:0]                          bank_q [gbc_io_pkg::BANK_COUNT];
   logic [gbc_io_pkg::BANK_COUNT-1:0]   hit;

   // One-hot match of the offset against the bank map
   always_comb begin
      for (int i = 0; i < gbc_io_pkg::BANK_COUNT; i++) begin
         hit[i] = (bank_acc.offset == gbc_io_pkg::BANK_OFS[i]);
      end
   end

   // ====================================================================
   // Storage
   // ====================================================================

   always_ff @(posedge clock_main) begin
      for (int i = 0; i < gbc_io_pkg::BANK_COUNT; i++) begin
         if (synch_reset) begin
            bank_q[i] <= gbc_io_pkg::BANK_RESET[i];
         end else if (bank_acc.we && hit[i]) begin
            // FF76/FF77 keep their reset value
            if (!gbc_io_pkg::BANK_READ_ONLY[i])
               bank_q[i] <= bank_acc.wdata;
         end
      end
   end

   // ====================================================================
   // Read port
   // ====================================================================

   always_comb begin
      bank_rdata = gbc_io_pkg::UNMAPPED_DATA;
      if (bank_acc.re) begin
         for (int i = 0; i < gbc_io_pkg::BANK_COUNT; i++) begin
            if (hit[i])
               bank_rdata = bank_q[i];
         end
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_gbc_io -o sim_tb_gbc_io

output=$(./obj_dir/sim_tb_gbc_io) || true
echo "$output"

if echo "$output" | grep -qF 'All tests passed!'; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed"
exit 1

//--- tb_gbc_io.sv
`default_nettype none

module tb_gbc_io;

   localparam int TIMEOUT_CYCLES = 20000;   // Divider wait dominates the run

   // Bank map in bus order, with the read-only flag per entry
   localparam logic [0:8][7:0] BANK_ADDR = '{
      8'h02, 8'h4D, 8'h6C, 8'h72, 8'h73, 8'h74, 8'h75, 8'h76, 8'h77
   };
   localparam logic [0:8][7:0] BANK_INIT = '{
      8'h7C, 8'hFD, 8'hFE, 8'h00, 8'h00, 8'h00, 8'h8F, 8'h00, 8'h00
   };
   localparam logic [0:8] BANK_RO = 9'b0_0000_0011;

   logic                 clock_main;
   logic                 synch_reset;
   gbc_io_pkg::io_req_t  cpu_req;
   gbc_io_pkg::irq_vec_t irq_sources;
   logic [7:0]           cpu_rdata;
   gbc_io_pkg::irq_vec_t irq_pending;
   logic [31:0]          lfsr_state;
   int                   cycle_count;

   gbc_io_top gbc_io_top_i (
      .clock_main  (clock_main),
      .synch_reset (synch_reset),
      .cpu_req     (cpu_req),
      .irq_sources (irq_sources),
      .cpu_rdata   (cpu_rdata),
      .irq_pending (irq_pending)
   );

   always #10 clock_main = ~clock_main;

   always @(posedge clock_main) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   // ====================================================================
   // Helpers
   // ====================================================================

   task automatic abort_run();
      $display("Test failures found");
      $fatal(1);
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_byte(output logic [7:0] value);
      for (int n = 0; n < 8; n++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value = {value[6:0], lfsr_state[0]};   // One step per bit
      end
   endtask

   task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s expected %02h, got %02h", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_irq(input string name, input gbc_io_pkg::irq_vec_t got,
                            input gbc_io_pkg::irq_vec_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s expected %05b, got %05b", $time, name, exp, got);
         abort_run();
      end
   endtask

   task automatic check_range(input string name, input logic [7:0] got,
                              input logic [7:0] lo, input logic [7:0] hi);
      if (got < lo || got > hi) begin
         $display("Mismatch at %0t: %s expected %02h..%02h, got %02h", $time, name, lo, hi, got);
         abort_run();
      end
   endtask

   task automatic io_write(input logic [15:0] address, input logic [7:0] data);
      @(posedge clock_main);
      cpu_req <= '{addr: address, wdata: data, we: 1'b1, re: 1'b0};
      @(posedge clock_main);   // Write lands here
      cpu_req.we <= 1'b0;
   endtask

   task automatic io_read(input logic [15:0] address, output logic [7:0] data);
      @(posedge clock_main);
      cpu_req <= '{addr: address, wdata: 8'h00, we: 1'b0, re: 1'b1};
      @(posedge clock_main);
      cpu_req.re <= 1'b0;
      @(negedge clock_main);
      data = cpu_rdata;
   endtask

   task automatic read_expect(input logic [15:0] address, input logic [7:0] exp,
                              input string name);
      logic [7:0] data;
      io_read(address, data);
      check_data(name, data, exp);
   endtask

   task automatic pulse_irq(input int line);
      @(posedge clock_main);
      irq_sources <= gbc_io_pkg::irq_vec_t'(5'b00001 << line);
      @(posedge clock_main);
      irq_sources <= '0;
   endtask

   // ====================================================================
   // Directed tests
   // ====================================================================

   task automatic reset_values();
      for (int i = 0; i < 9; i++)
         read_expect({8'hFF, BANK_ADDR[i]}, BANK_INIT[i], $sformatf("bank FF%02h", BANK_ADDR[i]));
      read_expect(16'hFF07, 8'hF8, "TAC");
      read_expect(16'hFF0F, 8'hE0, "IF");
      read_expect(16'hFFFF, 8'h00, "IE");
      read_expect(16'hFF01, 8'hFF, "unmapped FF01");
      read_expect(16'hFE05, 8'hFF, "off-page FE05");
      check_irq("irq_pending", irq_pending, '0);
   endtask

   task automatic bank_storage();
      logic [7:0] value;
      for (int i = 0; i < 9; i++) begin
         random_byte(value);
         io_write({8'hFF, BANK_ADDR[i]}, value);
         read_expect({8'hFF, BANK_ADDR[i]}, BANK_RO[i] ? BANK_INIT[i] : value,
                     $sformatf("bank FF%02h", BANK_ADDR[i]));
      end
   endtask

   task automatic irq_latching();
      logic [4:0] mask;
      logic [7:0] ie_val;
      mask = 5'b00000;
      for (int i = 0; i < 5; i++) begin
         if (i != 2) begin   // Timer line comes from inside
            pulse_irq(i);
            mask = mask | (5'b00001 << i);
            read_expect(16'hFF0F, {3'b111, mask}, "IF");
            check_irq("irq_pending", irq_pending, '0);
         end
      end
      random_byte(ie_val);
      io_write(16'hFFFF, ie_val);
      @(negedge clock_main);
      check_irq("irq_pending", irq_pending, gbc_io_pkg::irq_vec_t'(mask & ie_val[4:0]));
      read_expect(16'hFFFF, ie_val, "IE");
      io_write(16'hFFFF, 8'hFF);
      @(negedge clock_main);
      check_irq("irq_pending", irq_pending, gbc_io_pkg::irq_vec_t'(mask));
      io_write(16'hFF0F, 8'h00);
      @(negedge clock_main);
      check_irq("irq_pending", irq_pending, '0);
      io_write(16'hFFFF, 8'h00);
   endtask

   task automatic timer_overflow();
      logic [7:0] data;
      io_write(16'hFF06, 8'h40);   // TMA
      io_write(16'hFF05, 8'hFE);   // TIMA
      io_write(16'hFF07, 8'h05);   // Enabled, 16 cycle period
      repeat (48) @(posedge clock_main);
      io_read(16'hFF05, data);
      check_range("TIMA", data, 8'h40, 8'h47);
      read_expect(16'hFF0F, 8'hE4, "IF");
      io_write(16'hFFFF, 8'h04);
      @(negedge clock_main);
      check_irq("irq_pending", irq_pending, gbc_io_pkg::irq_vec_t'(5'b00100));
      io_write(16'hFF07, 8'h00);
      io_write(16'hFF0F, 8'h00);
      io_write(16'hFFFF, 8'h00);
   endtask

   task automatic divider_reset();
      logic [7:0] value;
      random_byte(value);
      io_write(16'hFF04, value);
      read_expect(16'hFF04, 8'h00, "DIV");
      repeat (300) @(posedge clock_main);
      read_expect(16'hFF04, 8'h01, "DIV");
   endtask

   // ====================================================================
   // Main sequence
   // ====================================================================

   initial begin
      clock_main  = 1'b0;
      synch_reset = 1'b1;
      cpu_req     = '0;
      irq_sources = '0;
      cycle_count = 0;
      lfsr_state  = 32'h63e4;
      repeat (5) @(posedge clock_main);
      synch_reset <= 1'b0;

      reset_values();
      bank_storage();
      irq_latching();
      timer_overflow();
      divider_reset();

      if (gbc_io_top_i.gbc_io_checker_i.assert_fail_count == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         $display("Bus checker reported assertion failures");
         abort_run();
      end
   end

endmodule

`default_nettype wire

//--- timer_unit.sv
`default_nettype none

module timer_unit (
   input  wire                          clock_main,
   input  wire                          synch_reset,
   input  wire gbc_io_pkg::io_access_t  timer_acc,
   output logic [7:0]                   timer_rdata,
   output logic                         timer_irq
);

   logic [15:0] div_count;   // Free-running prescaler, DIV is the top byte
   logic [7:0]  tima_q;
   logic [7:0]  tma_q;
   logic [2:0]  tac_q;       // Enable + clock select
   logic        tap_bit;
   logic        tap_prev;
   logic        tick;
   logic        div_wr;
   logic        tima_wr;
   logic        tma_wr;
   logic        tac_wr;

   assign div_wr  = timer_acc.we && (timer_acc.offset == gbc_io_pkg::DIV_OFS);
   assign tima_wr = timer_acc.we && (timer_acc.offset == gbc_io_pkg::TIMA_OFS);
   assign tma_wr  = timer_acc.we && (timer_acc.offset == gbc_io_pkg::TMA_OFS);
   assign tac_wr  = timer_acc.we && (timer_acc.offset == gbc_io_pkg::TAC_OFS);

   // ====================================================================
   // Prescaler tap and falling edge detect
   // ====================================================================

   always_comb begin
      case (tac_q[1:0])
         2'b00:   tap_bit = div_count[9];   // 1024 cycles
         2'b01:   tap_bit = div_count[3];   // 16
         2'b10:   tap_bit = div_count[5];   // 64
         default: tap_bit = div_count[7];   // 256
      endcase
   end

   assign tick = tac_q[2] & tap_prev & ~tap_bit;

   // ====================================================================
   // Counters
   // ====================================================================

   always_ff @(posedge clock_main) begin
      if (synch_reset) begin
         div_count <= '0;
         tap_prev  <= 1'b0;
         tima_q    <= '0;
         tma_q     <= '0;
         tac_q     <= '0;   // Timer stopped
         timer_irq <= 1'b0;
      end else begin
         div_count <= div_wr ? 16'h0000 : div_count + 16'd1;   // Any write clears
         tap_prev  <= tap_bit;
         timer_irq <= 1'b0;

         // CPU write beats a tick in the same cycle
         if (tima_wr) begin
            tima_q <= timer_acc.wdata;
         end else if (tick) begin
            if (tima_q == 8'hFF) begin
               tima_q    <= tma_q;   // Reload on wrap
               timer_irq <= 1'b1;
            end else begin
               tima_q <= tima_q + 8'd1;
            end
         end

         if (tma_wr)
            tma_q <= timer_acc.wdata;
         if (tac_wr)
            tac_q <= timer_acc.wdata[2:0];
      end
   end

   always_comb begin
      timer_rdata = gbc_io_pkg::UNMAPPED_DATA;
      if (timer_acc.re) begin
         case (timer_acc.offset)
            gbc_io_pkg::DIV_OFS:  timer_rdata = div_count[15:8];
            gbc_io_pkg::TIMA_OFS: timer_rdata = tima_q;
            gbc_io_pkg::TMA_OFS:  timer_rdata = tma_q;
            gbc_io_pkg::TAC_OFS:  timer_rdata = {5'b11111, tac_q};
            default:              timer_rdata = gbc_io_pkg::UNMAPPED_DATA;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
gbc_io_pkg.sv
io_bus_decoder.sv
io_register_bank.sv
timer_unit.sv
interrupt_unit.sv
gbc_io_top.sv
gbc_io_checker.sv
tb_gbc_io.sv
